/* hw/fetch_pkg.sv */
package fetch_pkg;

	// byte address width of the whole fetch path
	parameter int ADDR_W = 32;

	// one instruction is one 32-bit word
	parameter int INST_W = 32;

	// external RAM returns one byte per read
	parameter int BYTE_W = 8;

	// bytes that make up one instruction
	parameter int BYTES_PER_INST = INST_W / BYTE_W;

	// width of a byte offset inside an instruction word
	parameter int OFF_W = $clog2(BYTES_PER_INST);

	// cycles from lookup to valid strobe on a cache hit
	parameter int HIT_LATENCY = 1;

	// lookup, one request per byte, then the assemble cycle
	// grows by one cycle for every refused grant
	parameter int MISS_LATENCY = HIT_LATENCY + BYTES_PER_INST + 1;

	// a data read answers this many cycles after it is accepted
	parameter int MEM_RD_LATENCY = 2;

endpackage

/* hw/icache.sv */
`timescale 1ns/100ps

module icache #(
	parameter int ICACHE_INDEX_W = 4
) (
	input  logic                         clk,
	input  logic                         arst_n_i,

	// lookup side, answered in the same cycle
	input  logic [fetch_pkg::ADDR_W-1:0] rd_addr_i,
	output logic                         hit_o,
	output logic [fetch_pkg::INST_W-1:0] rd_data_o,

	// fill side, one word per strobe
	input  logic                         wr_en_i,
	input  logic [fetch_pkg::ADDR_W-1:0] wr_addr_i,
	input  logic [fetch_pkg::INST_W-1:0] wr_data_i
);

	// word address starts above the byte offset bits
	localparam int IDX_LO = fetch_pkg::OFF_W;
	localparam int TAG_LO = IDX_LO + ICACHE_INDEX_W;
	localparam int TAG_W  = fetch_pkg::ADDR_W - TAG_LO;
	localparam int LINES  = 1 << ICACHE_INDEX_W;

	// one tag, one word and one valid bit per line
	logic [TAG_W-1:0]             tag_mem  [LINES];
	logic [fetch_pkg::INST_W-1:0] data_mem [LINES];
	logic [LINES-1:0]             valid_q;

	logic [ICACHE_INDEX_W-1:0] rd_idx;
	logic [TAG_W-1:0]          rd_tag;
	logic [ICACHE_INDEX_W-1:0] wr_idx;
	logic [TAG_W-1:0]          wr_tag;

	// split both addresses into index and tag
	assign rd_idx = rd_addr_i[TAG_LO-1:IDX_LO];
	assign rd_tag = rd_addr_i[fetch_pkg::ADDR_W-1:TAG_LO];
	assign wr_idx = wr_addr_i[TAG_LO-1:IDX_LO];
	assign wr_tag = wr_addr_i[fetch_pkg::ADDR_W-1:TAG_LO];

	// combinational read
	// stale tag contents are masked by the valid bit
	assign hit_o     = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign rd_data_o = data_mem[rd_idx];

	// valid bits start cleared so nothing hits after reset
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;
		end else if (wr_en_i) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// tag and data written together on a fill
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tag_mem[wr_idx]  <= wr_tag;
			data_mem[wr_idx] <= wr_data_i;
		end
	end

	// a fill overwrites whatever line sat at the same index
	// no invalidation path, code is never modified

endmodule

/* hw/mem_ctrl.sv */
`timescale 1ns/100ps

module mem_ctrl (
	input  logic                         clk,
	input  logic                         arst_n_i,

	// data read port from the load/store side
	input  logic                         mem_rd_i,
	input  logic [fetch_pkg::ADDR_W-1:0] mem_addr_i,
	output logic                         mem_rvalid_o,
	output logic [fetch_pkg::BYTE_W-1:0] mem_rdata_o,

	// byte requests from instruction fetch
	input  logic                         fetch_req_i,
	input  logic [fetch_pkg::ADDR_W-1:0] fetch_addr_i,
	output logic                         fetch_grant_o,
	output logic                         fetch_byte_valid_o,
	output logic [fetch_pkg::BYTE_W-1:0] fetch_byte_o,

	// external byte RAM, data back one cycle after re
	output logic                         ram_re_o,
	output logic [fetch_pkg::ADDR_W-1:0] ram_addr_o,
	input  logic [fetch_pkg::BYTE_W-1:0] ram_rdata_i
);

	// data read waiting for or holding the port
	logic                         pend_q;
	logic [fetch_pkg::ADDR_W-1:0] pend_addr_q;

	// owner of the byte coming back this cycle
	logic own_data_q;
	logic own_fetch_q;

	logic accept;
	logic data_gnt;

	// only one data read in flight
	// a strobe while pending is dropped
	assign accept = mem_rd_i && !pend_q;

	// pending read goes out once
	// in its return cycle own_data_q blocks a second issue
	assign data_gnt = pend_q && !own_data_q;

	// data wins the port, fetch takes it otherwise
	assign fetch_grant_o = fetch_req_i && !data_gnt;

	assign ram_re_o   = data_gnt || fetch_req_i;
	assign ram_addr_o = data_gnt ? pend_addr_q : fetch_addr_i;

	// steer the returning byte to its owner
	assign mem_rvalid_o       = own_data_q;
	assign mem_rdata_o        = own_data_q ? ram_rdata_i : '0;
	assign fetch_byte_valid_o = own_fetch_q;
	assign fetch_byte_o       = own_fetch_q ? ram_rdata_i : '0;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pend_q      <= 1'b0;
			own_data_q  <= 1'b0;
			own_fetch_q <= 1'b0;
		end else begin
			// set on accept, cleared once the byte is back
			if (accept) begin
				pend_q <= 1'b1;
			end else if (own_data_q) begin
				pend_q <= 1'b0;
			end
			// at most one of these is set per cycle
			own_data_q  <= data_gnt;
			own_fetch_q <= fetch_grant_o;
		end
	end

	// address of the accepted read, held until it is issued
	always_ff @(posedge clk) begin
		if (accept) begin
			pend_addr_q <= mem_addr_i;
		end
	end

endmodule

/* hw/inst_fetch.sv */
`timescale 1ns/100ps

module inst_fetch #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic                         clk,
	input  logic                         arst_n_i,

	// pipeline control
	input  logic                         hold_i,
	input  logic                         branch_valid_i,
	input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,

	// towards decode
	output logic                         inst_valid_o,
	output logic [fetch_pkg::INST_W-1:0] inst_o,
	output logic [fetch_pkg::ADDR_W-1:0] pc_o,

	// byte requests through the memory controller
	output logic                         fetch_req_o,
	output logic [fetch_pkg::ADDR_W-1:0] fetch_addr_o,
	input  logic                         fetch_grant_i,
	input  logic                         fetch_byte_valid_i,
	input  logic [fetch_pkg::BYTE_W-1:0] fetch_byte_i,

	// instruction cache lookup and fill
	output logic [fetch_pkg::ADDR_W-1:0] cache_rd_addr_o,
	input  logic                         cache_hit_i,
	input  logic [fetch_pkg::INST_W-1:0] cache_rd_data_i,
	output logic                         cache_wr_en_o,
	output logic [fetch_pkg::ADDR_W-1:0] cache_wr_addr_o,
	output logic [fetch_pkg::INST_W-1:0] cache_wr_data_o
);

	localparam int NB    = fetch_pkg::BYTES_PER_INST;
	localparam int OFF_W = fetch_pkg::OFF_W;

	// three phases of one fetch
	localparam logic [1:0] S_LOOKUP   = 2'd0;
	localparam logic [1:0] S_REQ      = 2'd1;
	localparam logic [1:0] S_ASSEMBLE = 2'd2;

	// the hit path below is one register stage deep
	if (fetch_pkg::HIT_LATENCY != 1) begin : g_hit_latency
		$error("inst_fetch supports a hit latency of one cycle only");
	end

	logic [1:0]                   state_q;
	logic [fetch_pkg::ADDR_W-1:0] pc_q;

	// delivered instruction, valid held back while hold is high
	logic                         valid_q;
	logic [fetch_pkg::INST_W-1:0] inst_q;
	logic [fetch_pkg::ADDR_W-1:0] inst_pc_q;

	// miss bookkeeping
	// req_cnt_q counts granted bytes and is the next offset to ask for
	logic [OFF_W:0]   req_cnt_q;
	logic [OFF_W-1:0] gnt_off_q;
	logic             inflight_q;
	logic [NB-1:0]    filled_q;
	logic [NB-1:0][fetch_pkg::BYTE_W-1:0] bytes_q;

	// fill write, single cycle
	logic                         wr_en_q;
	logic [fetch_pkg::ADDR_W-1:0] wr_addr_q;
	logic [fetch_pkg::INST_W-1:0] wr_data_q;

	logic                         byte_take;
	logic [NB-1:0]                filled_nxt;
	logic [NB-1:0][fetch_pkg::BYTE_W-1:0] bytes_nxt;
	logic                         word_done;
	logic                         hit_take;
	logic                         word_take;
	logic [fetch_pkg::INST_W-1:0] word_asm;

	// byte from a request dropped by a branch is ignored
	assign byte_take = fetch_byte_valid_i && inflight_q;

	// merge the returning byte into the partial word
	always_comb begin
		filled_nxt = filled_q;
		bytes_nxt  = bytes_q;
		if (byte_take) begin
			filled_nxt[gnt_off_q] = 1'b1;
			bytes_nxt[gnt_off_q]  = fetch_byte_i;
		end
	end

	assign word_done = &filled_nxt;

	// byte 0 sits in the low bits, little-endian
	assign word_asm = bytes_nxt;

	// lookup completes on a hit, fill completes once all bytes are in
	assign hit_take  = (state_q == S_LOOKUP) && !hold_i && cache_hit_i;
	assign word_take = (state_q == S_ASSEMBLE) && word_done && !hold_i;

	// cache always looks at the current pc
	assign cache_rd_addr_o = pc_q;

	// request until four grants are in
	// a refused one repeats the same offset
	assign fetch_req_o  = (state_q == S_REQ);
	assign fetch_addr_o = {pc_q[fetch_pkg::ADDR_W-1:OFF_W], req_cnt_q[OFF_W-1:0]};

	assign inst_valid_o = valid_q && !hold_i;
	assign inst_o       = inst_q;
	assign pc_o         = inst_pc_q;

	assign cache_wr_en_o   = wr_en_q;
	assign cache_wr_addr_o = wr_addr_q;
	assign cache_wr_data_o = wr_data_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= S_LOOKUP;
			pc_q       <= RESET_PC;
			valid_q    <= 1'b0;
			req_cnt_q  <= '0;
			inflight_q <= 1'b0;
			filled_q   <= '0;
			wr_en_q    <= 1'b0;
		end else if (branch_valid_i) begin
			// redirect drops any partial miss and pending strobe
			state_q    <= S_LOOKUP;
			pc_q       <= branch_addr_i;
			valid_q    <= 1'b0;
			req_cnt_q  <= '0;
			inflight_q <= 1'b0;
			filled_q   <= '0;
			wr_en_q    <= 1'b0;
		end else begin
			wr_en_q    <= 1'b0;
			inflight_q <= fetch_grant_i;
			filled_q   <= filled_nxt;
			// strobe counts as taken once hold is low
			if (!hold_i) begin
				valid_q <= 1'b0;
			end
			case (state_q)
				S_LOOKUP: begin
					if (hit_take) begin
						valid_q <= 1'b1;
						pc_q    <= pc_q + fetch_pkg::ADDR_W'(NB);
					end else if (!hold_i) begin
						state_q <= S_REQ;
					end
				end
				S_REQ: begin
					// requests keep going during hold
					if (fetch_grant_i) begin
						req_cnt_q <= req_cnt_q + 1'b1;
						if (req_cnt_q == (OFF_W + 1)'(NB - 1)) begin
							state_q <= S_ASSEMBLE;
						end
					end
				end
				S_ASSEMBLE: begin
					// waits here for the last byte or for hold to drop
					if (word_take) begin
						valid_q   <= 1'b1;
						wr_en_q   <= 1'b1;
						pc_q      <= pc_q + fetch_pkg::ADDR_W'(NB);
						req_cnt_q <= '0;
						filled_q  <= '0;
						state_q   <= S_LOOKUP;
					end
				end
				default: begin
					state_q <= S_LOOKUP;
				end
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (fetch_grant_i) begin
			gnt_off_q <= req_cnt_q[OFF_W-1:0];
		end
		bytes_q <= bytes_nxt;
		if (hit_take) begin
			inst_q    <= cache_rd_data_i;
			inst_pc_q <= pc_q;
		end
		if (word_take) begin
			inst_q    <= word_asm;
			inst_pc_q <= pc_q;
			wr_addr_q <= pc_q;
			wr_data_q <= word_asm;
		end
	end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top #(
	parameter logic [31:0] RESET_PC       = 32'h0000_0000,
	parameter int          ICACHE_INDEX_W = 4
) (
	input  logic                         clk,
	input  logic                         arst_n_i,

	// pipeline steering
	input  logic                         hold_i,
	input  logic                         branch_valid_i,
	input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,

	// fetched instructions
	output logic                         inst_valid_o,
	output logic [fetch_pkg::INST_W-1:0] inst_o,
	output logic [fetch_pkg::ADDR_W-1:0] pc_o,

	// data read port
	input  logic                         mem_rd_i,
	input  logic [fetch_pkg::ADDR_W-1:0] mem_addr_i,
	output logic                         mem_rvalid_o,
	output logic [fetch_pkg::BYTE_W-1:0] mem_rdata_o,

	// byte RAM
	output logic                         ram_re_o,
	output logic [fetch_pkg::ADDR_W-1:0] ram_addr_o,
	input  logic [fetch_pkg::BYTE_W-1:0] ram_rdata_i
);

	// fetch to memory controller
	logic                         fetch_req;
	logic [fetch_pkg::ADDR_W-1:0] fetch_addr;
	logic                         fetch_grant;
	logic                         fetch_byte_valid;
	logic [fetch_pkg::BYTE_W-1:0] fetch_byte;

	// fetch to cache
	logic [fetch_pkg::ADDR_W-1:0] rd_addr;
	logic                         hit;
	logic [fetch_pkg::INST_W-1:0] rd_data;
	logic                         wr_en;
	logic [fetch_pkg::ADDR_W-1:0] wr_addr;
	logic [fetch_pkg::INST_W-1:0] wr_data;

	inst_fetch #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk                (clk),
		.arst_n_i           (arst_n_i),
		.hold_i             (hold_i),
		.branch_valid_i     (branch_valid_i),
		.branch_addr_i      (branch_addr_i),
		.inst_valid_o       (inst_valid_o),
		.inst_o             (inst_o),
		.pc_o               (pc_o),
		.fetch_req_o        (fetch_req),
		.fetch_addr_o       (fetch_addr),
		.fetch_grant_i      (fetch_grant),
		.fetch_byte_valid_i (fetch_byte_valid),
		.fetch_byte_i       (fetch_byte),
		.cache_rd_addr_o    (rd_addr),
		.cache_hit_i        (hit),
		.cache_rd_data_i    (rd_data),
		.cache_wr_en_o      (wr_en),
		.cache_wr_addr_o    (wr_addr),
		.cache_wr_data_o    (wr_data)
	);

	icache #(
		.ICACHE_INDEX_W (ICACHE_INDEX_W)
	) u_icache (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.rd_addr_i (rd_addr),
		.hit_o     (hit),
		.rd_data_o (rd_data),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data)
	);

	mem_ctrl u_mem_ctrl (
		.clk                (clk),
		.arst_n_i           (arst_n_i),
		.mem_rd_i           (mem_rd_i),
		.mem_addr_i         (mem_addr_i),
		.mem_rvalid_o       (mem_rvalid_o),
		.mem_rdata_o        (mem_rdata_o),
		.fetch_req_i        (fetch_req),
		.fetch_addr_i       (fetch_addr),
		.fetch_grant_o      (fetch_grant),
		.fetch_byte_valid_o (fetch_byte_valid),
		.fetch_byte_o       (fetch_byte),
		.ram_re_o           (ram_re_o),
		.ram_addr_o         (ram_addr_o),
		.ram_rdata_i        (ram_rdata_i)
	);

endmodule

/* testbench/fetch_assert.sv */
`timescale 1ns/100ps

module fetch_assert #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000,
	parameter int          INDEX_W  = 4
) (
	input logic                         clk,
	input logic                         arst_n_i,
	input logic                         hold_i,
	input logic                         branch_valid_i,
	input logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
	input logic                         inst_valid_i,
	input logic [fetch_pkg::INST_W-1:0] inst_i,
	input logic [fetch_pkg::ADDR_W-1:0] pc_i,
	input logic                         mem_rd_i,
	input logic [fetch_pkg::ADDR_W-1:0] mem_addr_i,
	input logic                         mem_rvalid_i,
	input logic [fetch_pkg::BYTE_W-1:0] mem_rdata_i,
	input logic                         ram_re_i,
	input logic                         fetch_req_i,
	input logic                         lookup_i,
	input logic [fetch_pkg::ADDR_W-1:0] rd_addr_i,
	input logic                         wr_en_i,
	input logic [fetch_pkg::ADDR_W-1:0] wr_addr_i
);

	// bytes per instruction and the cache address split
	localparam int NB     = fetch_pkg::INST_W / fetch_pkg::BYTE_W;
	localparam int IDX_LO = $clog2(NB);
	localparam int TAG_LO = IDX_LO + INDEX_W;
	localparam int TAG_W  = fetch_pkg::ADDR_W - TAG_LO;
	localparam int LINES  = 1 << INDEX_W;

	// filled lines by index
	logic [LINES-1:0] seen_q;
	logic [TAG_W-1:0] seen_tag_q [LINES];

	logic [fetch_pkg::ADDR_W-1:0] exp_pc_q;
	logic                         rd_busy_q;
	logic [fetch_pkg::ADDR_W-1:0] rd_addr_q;
	logic                         rd_accept;
	logic                         hit_expect;
	logic [INDEX_W-1:0]           look_idx;
	logic [INDEX_W-1:0]           fill_idx;

	// byte of the testbench RAM
	function automatic logic [7:0] ram_byte(input logic [31:0] a);
		return tb_fetch_top.ram[a[7:0]];
	endfunction

	// little-endian word with the lowest address in the low byte
	function automatic logic [31:0] ram_word(input logic [31:0] a);
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		b0 = tb_fetch_top.ram[a[7:0]];
		b1 = tb_fetch_top.ram[a[7:0] + 8'd1];
		b2 = tb_fetch_top.ram[a[7:0] + 8'd2];
		b3 = tb_fetch_top.ram[a[7:0] + 8'd3];
		return {b3, b2, b1, b0};
	endfunction

	assign look_idx = rd_addr_i[TAG_LO-1:IDX_LO];
	assign fill_idx = wr_addr_i[TAG_LO-1:IDX_LO];

	// lookup of a line filled earlier and still there
	assign hit_expect = lookup_i && !hold_i && !branch_valid_i && seen_q[look_idx]
		&& (seen_tag_q[look_idx] == rd_addr_i[fetch_pkg::ADDR_W-1:TAG_LO]);

	// one outstanding data read
	assign rd_accept = mem_rd_i && !rd_busy_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			seen_q    <= '0;
			exp_pc_q  <= RESET_PC;
			rd_busy_q <= 1'b0;
		end else begin
			if (wr_en_i) begin
				seen_q[fill_idx] <= 1'b1;
			end
			// branch target wins over a strobe in the same cycle
			if (branch_valid_i) begin
				exp_pc_q <= branch_addr_i;
			end else if (inst_valid_i) begin
				exp_pc_q <= pc_i + fetch_pkg::ADDR_W'(NB);
			end
			if (rd_accept) begin
				rd_busy_q <= 1'b1;
			end else if (mem_rvalid_i) begin
				rd_busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			seen_tag_q[fill_idx] <= wr_addr_i[fetch_pkg::ADDR_W-1:TAG_LO];
		end
		// address of the accepted read until its answer
		if (rd_accept) begin
			rd_addr_q <= mem_addr_i;
		end
	end

	// outputs quiet in reset and at the first edge after release
	a_reset_quiet: assert property (@(posedge clk)
		(!arst_n_i || $rose(arst_n_i)) |-> !inst_valid_i && !ram_re_i && !mem_rvalid_i)
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("strobe or RAM read seen during reset");
	end

	a_word: assert property (@(posedge clk) disable iff (!arst_n_i)
		inst_valid_i |-> inst_i == ram_word(pc_i))
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("ERROR inst_o got %h expected %h at pc_o %h",
			$sampled(inst_i), ram_word($sampled(pc_i)), $sampled(pc_i));
	end

	a_pc_seq: assert property (@(posedge clk) disable iff (!arst_n_i)
		inst_valid_i |-> pc_i == exp_pc_q)
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("ERROR pc_o got %h expected %h", $sampled(pc_i), $sampled(exp_pc_q));
	end

	// a hit needs no byte request
	a_hit: assert property (@(posedge clk) disable iff (!arst_n_i)
		$past(hit_expect, fetch_pkg::HIT_LATENCY) |-> (inst_valid_i || hold_i) && !fetch_req_i)
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("cached address was not delivered as a hit");
	end

	a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		hold_i |-> !inst_valid_i)
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("instruction strobe raised while hold was high");
	end

	a_rd_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
		$past(rd_accept, fetch_pkg::MEM_RD_LATENCY) |-> mem_rvalid_i)
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("accepted data read got no answer two cycles later");
	end

	a_rd_spurious: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_rvalid_i |-> $past(rd_accept, fetch_pkg::MEM_RD_LATENCY))
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("data answer with no accepted read behind it");
	end

	a_rd_data: assert property (@(posedge clk) disable iff (!arst_n_i)
		(mem_rvalid_i && $past(rd_accept, fetch_pkg::MEM_RD_LATENCY))
		|-> mem_rdata_i == ram_byte(rd_addr_q))
	else begin
		tb_fetch_top.err_cnt = tb_fetch_top.err_cnt + 1;
		$error("ERROR mem_rdata_o got %h expected %h",
			$sampled(mem_rdata_i), ram_byte($sampled(rd_addr_q)));
	end

endmodule

/* testbench/tb_fetch_top.sv */
`timescale 1ns/100ps

module tb_fetch_top;

	localparam logic [31:0] RESET_PC       = 32'h0000_0000;
	localparam int          ICACHE_INDEX_W = 4;

	// instructions per pass, then a branch
	localparam int PASS_LEN = 20;
	localparam int N_PASS   = 4;

	// every byte grant of a miss lost once to a data read
	localparam int WORST_MISS = fetch_pkg::MISS_LATENCY + fetch_pkg::BYTES_PER_INST;
	// holds stretch every instruction, so twice that plus reset and drain
	localparam int WATCHDOG_CYCLES = 2 * N_PASS * PASS_LEN * WORST_MISS + 200;

	logic        clk;
	logic        arst_n_i;
	logic        hold_i;
	logic        branch_valid_i;
	logic [31:0] branch_addr_i;
	logic        inst_valid_o;
	logic [31:0] inst_o;
	logic [31:0] pc_o;
	logic        mem_rd_i;
	logic [31:0] mem_addr_i;
	logic        mem_rvalid_o;
	logic [7:0]  mem_rdata_o;
	logic        ram_re_o;
	logic [31:0] ram_addr_o;
	logic [7:0]  ram_rdata_i;

	// byte RAM, also read by the checker
	logic [7:0] ram [256];

	int   err_cnt;
	int   inst_cnt;
	int   rd_cnt;
	logic stim_on;
	logic rd_busy;
	logic rd_en_s;
	logic [7:0] rd_addr_s;

	fetch_top #(
		.RESET_PC       (RESET_PC),
		.ICACHE_INDEX_W (ICACHE_INDEX_W)
	) u_dut (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.hold_i         (hold_i),
		.branch_valid_i (branch_valid_i),
		.branch_addr_i  (branch_addr_i),
		.inst_valid_o   (inst_valid_o),
		.inst_o         (inst_o),
		.pc_o           (pc_o),
		.mem_rd_i       (mem_rd_i),
		.mem_addr_i     (mem_addr_i),
		.mem_rvalid_o   (mem_rvalid_o),
		.mem_rdata_o    (mem_rdata_o),
		.ram_re_o       (ram_re_o),
		.ram_addr_o     (ram_addr_o),
		.ram_rdata_i    (ram_rdata_i)
	);

	// checker sees the DUT's own parameters and internal fetch wires
	bind fetch_top fetch_assert #(
		.RESET_PC (RESET_PC),
		.INDEX_W  (ICACHE_INDEX_W)
	) u_assert (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.hold_i         (hold_i),
		.branch_valid_i (branch_valid_i),
		.branch_addr_i  (branch_addr_i),
		.inst_valid_i   (inst_valid_o),
		.inst_i         (inst_o),
		.pc_i           (pc_o),
		.mem_rd_i       (mem_rd_i),
		.mem_addr_i     (mem_addr_i),
		.mem_rvalid_i   (mem_rvalid_o),
		.mem_rdata_i    (mem_rdata_o),
		.ram_re_i       (ram_re_o),
		.fetch_req_i    (fetch_req),
		.lookup_i       (u_fetch.state_q == 2'd0),
		.rd_addr_i      (rd_addr),
		.wr_en_i        (wr_en),
		.wr_addr_i      (wr_addr)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// RAM answers one cycle after a read enable
	always @(posedge clk) begin
		rd_en_s   = ram_re_o;
		rd_addr_s = ram_addr_o[7:0];
		#2;
		if (rd_en_s) begin
			ram_rdata_i = ram[rd_addr_s];
		end
	end

	// random hold and data reads
	// next read only once the previous one answered
	always @(posedge clk) begin
		if (mem_rvalid_o) begin
			rd_busy = 1'b0;
			rd_cnt  = rd_cnt + 1;
		end
		#2;
		mem_rd_i = 1'b0;
		if (stim_on) begin
			hold_i = (($urandom() % 8) == 0);
			if (!rd_busy && (($urandom() % 5) == 0)) begin
				mem_rd_i   = 1'b1;
				mem_addr_i = {24'h0, 8'($urandom())};
				rd_busy    = 1'b1;
			end
		end else begin
			hold_i = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (arst_n_i && inst_valid_o) begin
			inst_cnt = inst_cnt + 1;
		end
	end

	task automatic fill_ram();
		for (int i = 0; i < 256; i++) begin
			ram[i] = 8'($urandom());
		end
	endtask

	// returns once n more instructions went out
	task automatic wait_for_inst(input int n);
		int target;
		target = inst_cnt + n;
		while (inst_cnt < target) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic branch_to(input logic [31:0] target);
		@(posedge clk);
		#2;
		branch_valid_i = 1'b1;
		branch_addr_i  = target;
		@(posedge clk);
		#2;
		branch_valid_i = 1'b0;
	endtask

	initial begin
		arst_n_i       = 1'b0;
		hold_i         = 1'b0;
		branch_valid_i = 1'b0;
		branch_addr_i  = '0;
		mem_rd_i       = 1'b0;
		mem_addr_i     = '0;
		ram_rdata_i    = '0;
		err_cnt        = 0;
		inst_cnt       = 0;
		rd_cnt         = 0;
		stim_on        = 1'b0;
		rd_busy        = 1'b0;
		void'($urandom(82));
		fill_ram();
		repeat (10) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		stim_on  = 1'b1;
		// cold pass, then a partly warm one, a jump up and back to start
		wait_for_inst(PASS_LEN);
		branch_to(RESET_PC);
		wait_for_inst(PASS_LEN);
		branch_to(32'h0000_0040);
		wait_for_inst(PASS_LEN);
		branch_to(RESET_PC);
		wait_for_inst(PASS_LEN);
		stim_on = 1'b0;
		while (rd_busy) begin
			@(posedge clk);
			#1;
		end
		repeat (4) @(posedge clk);
		$display("errors=%0d instructions=%0d data_reads=%0d", err_cnt, inst_cnt, rd_cnt);
		if (err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("watchdog expired after %0d cycles before all passes finished",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

/* list.f */
hw/fetch_pkg.sv
hw/icache.sv
hw/mem_ctrl.sv
hw/inst_fetch.sv
hw/fetch_top.sv
testbench/fetch_assert.sv
testbench/tb_fetch_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_fetch_top
DUT_TOP   = fetch_top
FILELIST  = list.f
RTL_SRCS  = $(shell grep '^hw/' $(FILELIST))
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
